/* rv_pipeline_defs.svh */
`ifndef RV_PIPELINE_DEFS_SVH
`define RV_PIPELINE_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// Core widths
////////////////////////////////////////////////////////////////////////////

`define XLEN       32           // Data and address width
`define REG_COUNT  32           // Architectural registers
`define REG_IDX_W  5            // Register index width

////////////////////////////////////////////////////////////////////////////
// Fixed encodings
////////////////////////////////////////////////////////////////////////////

// ADDI x0, x0, 0
`define NOP_INST   32'h0000_0013

`define ZERO_REG   5'd0         // x0, hardwired zero
`define RESET_PC   32'h0000_0000 // First fetch address

`endif

/* rv_pipeline_pkg.sv */
`default_nettype none

`include "rv_pipeline_defs.svh"

package rv_pipeline_pkg;

    // RV32I major opcodes in use
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT
    } alu_op_e;

    // Unified memory port command
    typedef enum logic [1:0] {
        BUS_NONE  = 2'd0,
        BUS_LOAD  = 2'd1,
        BUS_STORE = 2'd2
    } bus_cmd_e;

    ////////////////////////////////////////////////////////////////////////////
    // Stage packets
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [31:0]       inst;
        logic [`XLEN-1:0]  pc;
        logic              valid;
    } fetch_pkt_t;

    typedef struct packed {
        logic [`XLEN-1:0]      pc;
        logic [`XLEN-1:0]      rs1_val;  // Already forwarded
        logic [`XLEN-1:0]      rs2_val;
        logic [`XLEN-1:0]      imm;
        logic [`REG_IDX_W-1:0] rd;
        alu_op_e               alu_op;
        logic                  use_imm;  // Operand b from imm
        logic                  is_load;
        logic                  is_store;
        logic                  br_eq;
        logic                  br_ne;
        logic                  halt;     // ECALL
        logic                  wr_reg;   // Never set for x0
        logic                  valid;
    } decode_pkt_t;

    typedef struct packed {
        logic [`XLEN-1:0]      pc;
        logic [`XLEN-1:0]      result;     // ALU result or load/store address
        logic [`XLEN-1:0]      store_data;
        logic [`REG_IDX_W-1:0] rd;
        logic                  is_load;
        logic                  is_store;
        logic                  halt;
        logic                  wr_reg;
        logic                  valid;
        logic                  br_taken;
        logic [`XLEN-1:0]      br_target;
    } exec_pkt_t;

    // Bypass source into decode
    typedef struct packed {
        logic                  valid;
        logic [`REG_IDX_W-1:0] rd;
        logic [`XLEN-1:0]      value;
        logic                  is_load;
    } fwd_t;

    typedef struct packed {
        logic             taken;
        logic [`XLEN-1:0] target;
    } redirect_t;

    // Retired instruction, also the register file write
    typedef struct packed {
        logic                  valid;
        logic [`XLEN-1:0]      pc;
        logic                  wr_en;
        logic [`REG_IDX_W-1:0] wr_idx;
        logic [`XLEN-1:0]      wr_data;
    } commit_t;

endpackage

`default_nettype wire

/* fetch_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_pipeline_defs.svh"

module fetch_stage import rv_pipeline_pkg::*; (
    input  logic             clock,
    input  logic             reset,
    input  logic             ready,      // Decode takes the slot
    input  logic             bus_grant,  // Memory stage leaves the port free
    input  redirect_t        redirect,
    input  logic [`XLEN-1:0] mem_rdata,
    output logic [`XLEN-1:0] fetch_addr,
    output fetch_pkt_t       fetch_out
);

    logic [`XLEN-1:0] pc;
    logic             slot_open;

    // Slot empty, or its packet leaves this edge
    assign slot_open  = !fetch_out.valid || ready;
    assign fetch_addr = pc; // Offered every cycle, used only when granted

    ////////////////////////////////////////////////////////////////////////////
    // PC and instruction slot
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            pc              <= `RESET_PC;
            fetch_out.valid <= 1'b0;
        end else if (redirect.taken) begin
            pc              <= redirect.target; // Squash whatever was in flight
            fetch_out.valid <= 1'b0;
        end else if (slot_open) begin
            if (bus_grant) begin
                fetch_out.inst  <= mem_rdata; // Same-cycle read
                fetch_out.pc    <= pc;
                fetch_out.valid <= 1'b1;
                pc              <= pc + `XLEN'd4;
            end else begin
                fetch_out.valid <= 1'b0; // Port taken by a load or store
            end
        end
        // Otherwise hold packet and pc for decode
    end

endmodule

`default_nettype wire

/* register_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_pipeline_defs.svh"

module register_file (
    input  logic                  clock,
    input  logic                  reset,
    input  logic [`REG_IDX_W-1:0] rs1_idx,
    input  logic [`REG_IDX_W-1:0] rs2_idx,
    input  logic                  wr_en,
    input  logic [`REG_IDX_W-1:0] wr_idx,
    input  logic [`XLEN-1:0]      wr_data,
    output logic [`XLEN-1:0]      rs1_data,
    output logic [`XLEN-1:0]      rs2_data
);

    logic [`XLEN-1:0] regs [`REG_COUNT];
    logic             write;

    assign write = wr_en && !reset && (wr_idx != `ZERO_REG);

    always_ff @(posedge clock) begin
        if (write) regs[wr_idx] <= wr_data;
    end

    // x0 reads zero, same-cycle write wins over the array
    assign rs1_data = (rs1_idx == `ZERO_REG)            ? '0      :
                      (write && (wr_idx == rs1_idx))    ? wr_data : regs[rs1_idx];
    assign rs2_data = (rs2_idx == `ZERO_REG)            ? '0      :
                      (write && (wr_idx == rs2_idx))    ? wr_data : regs[rs2_idx];

endmodule

`default_nettype wire

/* decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_pipeline_defs.svh"

module decode_stage import rv_pipeline_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  fetch_pkt_t  fetch_in,
    output logic        ready,
    input  fwd_t        ex_fwd,     // Instruction one ahead
    input  fwd_t        mem_fwd,    // Instruction two ahead
    input  redirect_t   redirect,
    input  commit_t     wb_commit,  // Register file write
    output decode_pkt_t decode_out
);

    logic [31:0]           inst;
    opcode_e               opcode;
    logic [2:0]            funct3;
    logic [`REG_IDX_W-1:0] rs1, rs2, rd;
    logic [`XLEN-1:0]      rf_rs1, rf_rs2;
    logic                  use_rs1, use_rs2;
    logic                  load_use;
    decode_pkt_t           dec;

    assign inst   = fetch_in.inst;
    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign rd     = inst[11:7];

    register_file u_regfile (
        .clock    (clock),
        .reset    (reset),
        .rs1_idx  (rs1),
        .rs2_idx  (rs2),
        .wr_en    (wb_commit.valid && wb_commit.wr_en),
        .wr_idx   (wb_commit.wr_idx),
        .wr_data  (wb_commit.wr_data),
        .rs1_data (rf_rs1),
        .rs2_data (rf_rs2)
    );

    // Nearer producer first, x0 never forwarded
    function automatic logic [`XLEN-1:0] pick(input logic [`REG_IDX_W-1:0] idx,
                                              input logic [`XLEN-1:0]      rf_val);
        if (idx == `ZERO_REG) return '0;
        if (ex_fwd.valid && (ex_fwd.rd == idx)) return ex_fwd.value;
        if (mem_fwd.valid && (mem_fwd.rd == idx)) return mem_fwd.value;
        return rf_val;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Decoder
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        dec        = '0;
        dec.pc     = fetch_in.pc;
        dec.rd     = rd;
        dec.alu_op = ALU_ADD; // Address math for loads and stores
        use_rs1    = 1'b0;
        use_rs2    = 1'b0;
        case (opcode)
            OPC_OP: begin
                use_rs1    = 1'b1;
                use_rs2    = 1'b1;
                dec.wr_reg = 1'b1;
                case (funct3)
                    3'b000:  dec.alu_op = inst[30] ? ALU_SUB : ALU_ADD;
                    3'b010:  dec.alu_op = ALU_SLT;
                    3'b100:  dec.alu_op = ALU_XOR;
                    3'b110:  dec.alu_op = ALU_OR;
                    3'b111:  dec.alu_op = ALU_AND;
                    default: dec.alu_op = ALU_ADD;
                endcase
            end
            OPC_OP_IMM, OPC_LOAD: begin // ADDI and LW share the I immediate
                use_rs1     = 1'b1;
                dec.use_imm = 1'b1;
                dec.imm     = {{20{inst[31]}}, inst[31:20]};
                dec.is_load = (opcode == OPC_LOAD);
                dec.wr_reg  = 1'b1;
            end
            OPC_STORE: begin
                use_rs1      = 1'b1;
                use_rs2      = 1'b1; // Store data
                dec.use_imm  = 1'b1;
                dec.imm      = {{20{inst[31]}}, inst[31:25], inst[11:7]};
                dec.is_store = 1'b1;
            end
            OPC_BRANCH: begin
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
                dec.imm   = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
                dec.br_eq = (funct3 == 3'b000);
                dec.br_ne = (funct3 == 3'b001);
            end
            OPC_SYSTEM: dec.halt = 1'b1;
            default: ; // Unsupported, passes as a bubble-like no-op
        endcase
        if (rd == `ZERO_REG) dec.wr_reg = 1'b0; // x0 writes dropped here
        dec.rs1_val = pick(rs1, rf_rs1);
        dec.rs2_val = pick(rs2, rf_rs2);
        dec.valid   = fetch_in.valid && !load_use && !redirect.taken;
    end

    // Load in execute feeding this instruction, value not ready yet
    assign load_use = fetch_in.valid && ex_fwd.valid && ex_fwd.is_load &&
                      ((use_rs1 && (ex_fwd.rd == rs1)) || (use_rs2 && (ex_fwd.rd == rs2)));
    assign ready    = !load_use;

    always_ff @(posedge clock) begin
        if (reset) decode_out.valid <= 1'b0;
        else       decode_out       <= dec; // Bubble when valid is low
    end

endmodule

`default_nettype wire

/* execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_pipeline_defs.svh"

module execute_stage import rv_pipeline_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  decode_pkt_t decode_in,
    output fwd_t        ex_fwd,
    output exec_pkt_t   exec_out,
    output redirect_t   redirect
);

    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] alu_result;
    logic             equal;
    logic             taken;
    exec_pkt_t        ex_next;

    ////////////////////////////////////////////////////////////////////////////
    // ALU and branch compare
    ////////////////////////////////////////////////////////////////////////////

    assign op_b = decode_in.use_imm ? decode_in.imm : decode_in.rs2_val;

    always_comb begin
        case (decode_in.alu_op)
            ALU_SUB: alu_result = decode_in.rs1_val - op_b;
            ALU_AND: alu_result = decode_in.rs1_val & op_b;
            ALU_OR:  alu_result = decode_in.rs1_val | op_b;
            ALU_XOR: alu_result = decode_in.rs1_val ^ op_b;
            ALU_SLT: alu_result = {{(`XLEN-1){1'b0}},
                                   ($signed(decode_in.rs1_val) < $signed(op_b))};
            default: alu_result = decode_in.rs1_val + op_b; // Also load/store address
        endcase
    end

    assign equal = (decode_in.rs1_val == decode_in.rs2_val);
    assign taken = decode_in.valid && ((decode_in.br_eq && equal) || (decode_in.br_ne && !equal));

    // Result one stage early, address only for a load
    assign ex_fwd.valid   = decode_in.valid && decode_in.wr_reg;
    assign ex_fwd.rd      = decode_in.rd;
    assign ex_fwd.value   = alu_result;
    assign ex_fwd.is_load = decode_in.is_load;

    always_comb begin
        ex_next            = '0;
        ex_next.pc         = decode_in.pc;
        ex_next.result     = alu_result;
        ex_next.store_data = decode_in.rs2_val;
        ex_next.rd         = decode_in.rd;
        ex_next.is_load    = decode_in.is_load;
        ex_next.is_store   = decode_in.is_store;
        ex_next.halt       = decode_in.halt;
        ex_next.wr_reg     = decode_in.wr_reg;
        ex_next.br_target  = decode_in.pc + decode_in.imm;
        // Our own taken branch squashes the instruction behind it
        ex_next.valid      = decode_in.valid && !redirect.taken;
        ex_next.br_taken   = taken && !redirect.taken;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            exec_out.valid    <= 1'b0;
            exec_out.br_taken <= 1'b0;
        end else begin
            exec_out <= ex_next;
        end
    end

    // Redirect from the register, seen by fetch, decode and here
    assign redirect.taken  = exec_out.valid && exec_out.br_taken;
    assign redirect.target = exec_out.br_target;

endmodule

`default_nettype wire

/* memory_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_pipeline_defs.svh"

module memory_stage import rv_pipeline_pkg::*; (
    input  logic             clock,
    input  logic             reset,
    input  exec_pkt_t        exec_in,
    input  logic [`XLEN-1:0] fetch_addr,
    input  logic [`XLEN-1:0] mem_rdata,
    output bus_cmd_e         mem_cmd,
    output logic [`XLEN-1:0] mem_addr,
    output logic [`XLEN-1:0] mem_wdata,
    output logic             bus_grant,  // Port free for fetch
    output fwd_t             mem_fwd,
    output commit_t          commit,     // Writeback register
    output logic             halted
);

    logic             live;     // Valid and not past the halt
    logic             data_op;
    logic [`XLEN-1:0] wb_value;

    assign live    = exec_in.valid && !halted;
    assign data_op = live && (exec_in.is_load || exec_in.is_store);

    ////////////////////////////////////////////////////////////////////////////
    // Port arbitration, data access beats fetch
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        if (data_op) begin
            mem_cmd  = exec_in.is_store ? BUS_STORE : BUS_LOAD;
            mem_addr = exec_in.result;
        end else begin
            mem_cmd  = BUS_LOAD; // Instruction fetch
            mem_addr = fetch_addr;
        end
    end

    assign mem_wdata = exec_in.store_data;
    assign bus_grant = !data_op;

    // Load data arrives this cycle
    assign wb_value = exec_in.is_load ? mem_rdata : exec_in.result;

    assign mem_fwd.valid   = exec_in.valid && exec_in.wr_reg;
    assign mem_fwd.rd      = exec_in.rd;
    assign mem_fwd.value   = wb_value;
    assign mem_fwd.is_load = exec_in.is_load;

    always_ff @(posedge clock) begin
        if (reset) begin
            commit.valid <= 1'b0;
            commit.wr_en <= 1'b0;
            halted       <= 1'b0;
        end else begin
            commit.valid   <= live; // Nothing retires after the halt
            commit.pc      <= exec_in.pc;
            commit.wr_en   <= live && exec_in.wr_reg;
            commit.wr_idx  <= exec_in.rd;
            commit.wr_data <= wb_value;
            if (live && exec_in.halt) halted <= 1'b1; // Sticky
        end
    end

endmodule

`default_nettype wire

/* rv_pipeline.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_pipeline_defs.svh"

module rv_pipeline import rv_pipeline_pkg::*; (
    input  logic             clock,
    input  logic             reset,
    input  logic [`XLEN-1:0] mem_rdata,
    output bus_cmd_e         mem_cmd,
    output logic [`XLEN-1:0] mem_addr,
    output logic [`XLEN-1:0] mem_wdata,
    output commit_t          commit,
    output logic             halted
);

    fetch_pkt_t       fetch_pkt;
    logic             dec_ready;
    logic             bus_grant;
    logic [`XLEN-1:0] fetch_addr;
    redirect_t        redirect;
    fwd_t             ex_fwd, mem_fwd;
    decode_pkt_t      decode_pkt;
    exec_pkt_t        exec_pkt;

    ////////////////////////////////////////////////////////////////////////////
    // Stages
    ////////////////////////////////////////////////////////////////////////////

    fetch_stage u_fetch (
        .clock      (clock),
        .reset      (reset),
        .ready      (dec_ready),
        .bus_grant  (bus_grant),
        .redirect   (redirect),
        .mem_rdata  (mem_rdata),
        .fetch_addr (fetch_addr),
        .fetch_out  (fetch_pkt)
    );

    decode_stage u_decode (
        .clock      (clock),
        .reset      (reset),
        .fetch_in   (fetch_pkt),
        .ready      (dec_ready),
        .ex_fwd     (ex_fwd),
        .mem_fwd    (mem_fwd),
        .redirect   (redirect),
        .wb_commit  (commit),     // Commit doubles as writeback
        .decode_out (decode_pkt)
    );

    execute_stage u_execute (
        .clock     (clock),
        .reset     (reset),
        .decode_in (decode_pkt),
        .ex_fwd    (ex_fwd),
        .exec_out  (exec_pkt),
        .redirect  (redirect)
    );

    memory_stage u_memory (
        .clock      (clock),
        .reset      (reset),
        .exec_in    (exec_pkt),
        .fetch_addr (fetch_addr),
        .mem_rdata  (mem_rdata),
        .mem_cmd    (mem_cmd),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .bus_grant  (bus_grant),
        .mem_fwd    (mem_fwd),
        .commit     (commit),
        .halted     (halted)
    );

endmodule

`default_nettype wire

/* commit_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_pipeline_defs.svh"

module commit_checker import rv_pipeline_pkg::*; #(
    parameter int MEM_WORDS = 1024,
    parameter int MAX_EXP   = 64,
    parameter int SETTLE    = 16      // Cycles watched after the halt
) (
    input  logic                  clock,
    input  logic                  reset,
    input  commit_t               commit,
    input  logic                  halted,
    input  bus_cmd_e              mem_cmd,
    input  logic [`XLEN-1:0]      mem_addr,
    input  logic [31:0]           mem [MEM_WORDS],
    input  int                    w_count,
    input  logic [`REG_IDX_W-1:0] w_idx [MAX_EXP],
    input  logic [31:0]           w_data [MAX_EXP],
    input  logic [127:0]          w_name [MAX_EXP],
    input  int                    m_count,
    input  logic [31:0]           m_addr [MAX_EXP],
    input  logic [31:0]           m_data [MAX_EXP],
    input  logic [127:0]          m_name [MAX_EXP],
    output logic                  done,
    output int                    value_errors,
    output int                    other_errors
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    int          w_pos       = 0;  // Next expected write
    int          halt_cycles = 0;
    logic [31:0] last_pc;          // Pc of the previous commit
    logic        seen_commit;

    // One register write against the next W entry
    task automatic compare_write();
        logic [31:0] word;
        if (w_pos >= w_count) begin
            $display("Unexpected register write x%0d = %h at pc %h, none left to expect",
                     commit.wr_idx, commit.wr_data, commit.pc);
            other_errors++;
        end else begin
            if ((commit.wr_idx !== w_idx[w_pos]) || (commit.wr_data !== w_data[w_pos])) begin
                $display("** Error %0s: write %0d expected x%0d = %h, actual x%0d = %h",
                         w_name[w_pos], w_pos, w_idx[w_pos], w_data[w_pos],
                         commit.wr_idx, commit.wr_data);
                value_errors++;
            end
            // Rd field of the word at the committed pc
            word = mem[commit.pc[IDX_W+1:2]];
            if (word[11:7] !== commit.wr_idx) begin
                $display("** Error %0s: write %0d at pc %h expected rd x%0d, actual x%0d",
                         w_name[w_pos], w_pos, commit.pc, word[11:7], commit.wr_idx);
                value_errors++;
            end
            w_pos++;
        end
    endtask

    // Only forward branches in the program, so pcs climb
    task automatic check_order();
        if (seen_commit && (commit.pc <= last_pc)) begin
            $display("Commit at pc %h came after pc %h, out of program order",
                     commit.pc, last_pc);
            other_errors++;
        end
        last_pc     = commit.pc;
        seen_commit = 1'b1;
    endtask

    task automatic compare_memory();
        logic [31:0] word;
        for (int i = 0; i < m_count; i++) begin
            word = mem[m_addr[i][IDX_W+1:2]];
            if (word !== m_data[i]) begin
                $display("** Error %0s: mem[%h] expected %h, actual %h",
                         m_name[i], m_addr[i], m_data[i], word);
                value_errors++;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Sampled mid-cycle, away from the clock edge
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clock) begin
        if (reset) begin
            w_pos        = 0;
            halt_cycles  = 0;
            last_pc      = '0;
            seen_commit  = 1'b0;
            done         = 1'b0;
            value_errors = 0;
            other_errors = 0;
        end else if (!done) begin
            if (halt_cycles == 0) begin
                if (commit.valid) check_order();
                if (commit.valid && commit.wr_en) compare_write();
                if (halted) halt_cycles = 1; // ECALL commit is visible now
            end else begin
                if (commit.valid) begin
                    $display("Commit at pc %h after the halt", commit.pc);
                    other_errors++;
                end
                halt_cycles++;
            end
            if (halted && (mem_cmd == BUS_STORE)) begin
                $display("Store to %h issued after the halt", mem_addr);
                other_errors++;
            end
            if (halt_cycles > SETTLE) begin
                if (w_pos < w_count) begin
                    $display("%0d expected register writes never committed, first from %0s",
                             w_count - w_pos, w_name[w_pos]);
                    other_errors++;
                end
                compare_memory();
                done = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* tb_rv_pipeline.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_pipeline_defs.svh"

module tb_rv_pipeline import rv_pipeline_pkg::*; ();

    localparam int    PERIOD    = 8;
    localparam int    MEM_WORDS = 1024;
    localparam int    IDX_W     = $clog2(MEM_WORDS);
    localparam int    MAX_EXP   = 64;
    localparam int    SEED      = 32'hc578_2a0b;
    localparam string DATA_FILE = "rv_pipeline_testdata.txt";

    logic             clock;
    logic             reset;
    logic [`XLEN-1:0] mem_rdata;
    bus_cmd_e         mem_cmd;
    logic [`XLEN-1:0] mem_addr;
    logic [`XLEN-1:0] mem_wdata;
    commit_t          commit;
    logic             halted;

    logic [31:0]           mem   [MEM_WORDS];  // Live memory model
    logic [31:0]           image [MEM_WORDS];  // Contents copied in during reset
    logic [`REG_IDX_W-1:0] w_idx [MAX_EXP];
    logic [31:0]           w_data [MAX_EXP];
    logic [127:0]          w_name [MAX_EXP];
    logic [31:0]           m_addr [MAX_EXP];
    logic [31:0]           m_data [MAX_EXP];
    logic [127:0]          m_name [MAX_EXP];
    int                    w_count     = 0;
    int                    m_count     = 0;
    int                    prog_words  = 0;
    int                    load_errors = 0;
    logic                  loaded      = 1'b0;
    logic                  done;
    int                    value_errors;
    int                    other_errors;

    rv_pipeline dut (
        .clock     (clock),
        .reset     (reset),
        .mem_rdata (mem_rdata),
        .mem_cmd   (mem_cmd),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .commit    (commit),
        .halted    (halted)
    );

    commit_checker #(.MEM_WORDS(MEM_WORDS), .MAX_EXP(MAX_EXP)) u_checker (
        .clock (clock), .reset (reset), .commit (commit), .halted (halted),
        .mem_cmd (mem_cmd), .mem_addr (mem_addr), .mem (mem),
        .w_count (w_count), .w_idx (w_idx), .w_data (w_data), .w_name (w_name),
        .m_count (m_count), .m_addr (m_addr), .m_data (m_data), .m_name (m_name),
        .done (done), .value_errors (value_errors), .other_errors (other_errors)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Memory model, same-cycle read
    ////////////////////////////////////////////////////////////////////////////

    assign mem_rdata = mem[mem_addr[IDX_W+1:2]];

    always @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < MEM_WORDS; i++) mem[i] <= image[i];
        end else if (mem_cmd == BUS_STORE) begin
            mem[mem_addr[IDX_W+1:2]] <= mem_wdata;
        end
    end

    // Filler for everything the data file leaves out
    task automatic fill_image();
        for (int i = 0; i < MEM_WORDS; i++) image[i] = $urandom();
    endtask

    task automatic load_testdata();
        int           fd;
        int           n;
        string        line;
        logic [7:0]   kind;
        logic [127:0] name;
        logic [31:0]  a;
        logic [31:0]  b;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open %s for reading", DATA_FILE);
            load_errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n    = $fgets(line, fd);
            if ((n > 0) && (line.len() > 1) && (line[0] != "#")) begin
                n = $sscanf(line, "%s %s %h %h", kind, name, a, b);
                if (n != 4) begin
                    $display("Malformed data line: %s", line);
                    load_errors++;
                end else if (kind == "I") begin
                    image[a[IDX_W+1:2]] = b;
                    prog_words++;
                end else if ((kind == "W") && (w_count < MAX_EXP)) begin
                    w_idx[w_count]  = a[`REG_IDX_W-1:0];
                    w_data[w_count] = b;
                    w_name[w_count] = name;
                    w_count++;
                end else if ((kind == "M") && (m_count < MAX_EXP)) begin
                    m_addr[m_count] = a;
                    m_data[m_count] = b;
                    m_name[m_count] = name;
                    m_count++;
                end else begin
                    $display("Unknown or overflowing data line: %s", line);
                    load_errors++;
                end
            end
        end
        $fclose(fd);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Clock, reset, watchdog and the end of the run
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    initial begin
        void'($urandom(SEED)); // Seed for the filler
        reset = 1'b1;
        fill_image();
        load_testdata();
        loaded = 1'b1;
        repeat (4) @(negedge clock); // Four rising edges in reset
        reset = 1'b0;
    end

    initial begin
        wait (loaded === 1'b1);
        #((8 * prog_words + 100) * PERIOD);
        $display("Timeout: the core did not halt within %0d cycles", 8 * prog_words + 100);
        $display("Checks failed");
        $finish;
    end

    initial begin
        wait (done === 1'b1);
        $display("Summary: %0d value errors, %0d other errors, %0d data file errors",
                 value_errors, other_errors, load_errors);
        if ((value_errors == 0) && (other_errors == 0) && (load_errors == 0) && (w_count > 0))
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

/* rv_pipeline.f */
+incdir+.
rv_pipeline_pkg.sv
fetch_stage.sv
register_file.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
rv_pipeline.sv
commit_checker.sv
tb_rv_pipeline.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rv_pipeline
FILELIST  ?= rv_pipeline.f
FLAGS     ?= --binary --timing -Wno-fatal
OBJDIR    ?= obj_dir
PASS_MSG  ?= All checks passed

.PHONY: compile run clean

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

/* rv_pipeline_testdata.txt */
# kind test addr/index data (hex)
# I = memory image word, W = expected register write in commit order, M = final memory word
I alu_fwd    00000000 00500093
I alu_fwd    00000004 00708113
I alu_fwd    00000008 002081b3
I alu_fwd    0000000c 40118233
I alu_fwd    00000010 001262b3
I alu_fwd    00000014 0032f333
I alu_fwd    00000018 005343b3
I alu_fwd    0000001c 00322433
I alu_fwd    00000020 ffd00493
I alu_fwd    00000024 0014a533
I load_use   00000028 10002583
I load_use   0000002c 00158633
I store_load 00000030 10302223
I store_load 00000034 10402683
I store_load 00000038 00168713
I branch     0000003c 00410863
I branch     00000040 00100793
I branch     00000044 00200793
I branch     00000048 00300793
I branch     0000004c 04400813
I branch     00000050 00109463
I branch     00000054 00900893
I branch     00000058 00209863
I branch     0000005c 00100913
I branch     00000060 00200913
I branch     00000064 00300913
I branch     00000068 00208463
I branch     0000006c 05500993
I x0_write   00000070 04d00013
I x0_write   00000074 00208033
I x0_write   00000078 00100a33
I x0_write   0000007c 00000ab3
I halt       00000080 00000073
I halt       00000084 00100b13
I halt       00000088 10102623
I halt       0000008c 00200b93
I load_use   00000100 cafe0123
I store_load 00000104 00000000
I halt       0000010c deadbeef
W alu_fwd    01 00000005
W alu_fwd    02 0000000c
W alu_fwd    03 00000011
W alu_fwd    04 0000000c
W alu_fwd    05 0000000d
W alu_fwd    06 00000001
W alu_fwd    07 0000000c
W alu_fwd    08 00000001
W alu_fwd    09 fffffffd
W alu_fwd    0a 00000001
W load_use   0b cafe0123
W load_use   0c cafe0128
W store_load 0d 00000011
W store_load 0e 00000012
W branch     10 00000044
W branch     11 00000009
W branch     13 00000055
W x0_write   14 00000005
W x0_write   15 00000000
M load_use   00000100 cafe0123
M store_load 00000104 00000011
M halt       0000010c deadbeef
